//--- snn_cases.txt
# pattern in hex with bit n for neuron n, lif latency, learning latency, expected spikes
# latencies count clock cycles after the engine start pulse and are at least 1
a5 1 1 4
00 2 3 0
ff 1 2 8
81 4 1 2
3c 3 5 4
01 6 2 1
80 1 7 1

//--- flist.f
snn_sched_pkg.sv
sched_fsm.sv
engine_pulses.sv
sram_strobes.sv
snn_scheduler.sv
tb_snn_scheduler.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f flist.f --top-module tb_snn_scheduler -o sim_snn \
    && ./obj_dir/sim_snn | tee sim.log \
    || { echo "build or run failed"; exit 1; }
grep -q "^PASS: all tests$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb_snn_scheduler.sv
// snn scheduler testbench acting as the lif unit and learning engine over a case file
`default_nettype none

module tb_snn_scheduler;

    localparam int neurons = 8;
    localparam int proc_delay = 3;
    localparam int max_cases = 16;
    localparam logic [2:0] last_num = 3'(neurons - 1);

    logic       clk;
    logic       rst;
    logic       start_snn_compute;
    logic       spike_valid;
    logic       spike_output_lif;
    logic       output_valid_learning_engine;
    logic       start_lif;
    logic       start_processing_engine;
    logic       last_one_processing_engine;
    logic       spike_output_processing_engine;
    logic       start_learning_engine;
    logic       spike_output_learning_engine;
    logic [2:0] bias_and_encoders_sram_address;
    logic       bias_and_encoders_sram_chip_select;
    logic [1:0] refractory_time_sram_address;
    logic       refractory_time_sram_data_select;
    logic       refractory_time_sram_chip_select;
    logic       refractory_time_sram_write_enable;
    logic [2:0] voltage_sram_address;
    logic       voltage_sram_chip_select;
    logic       voltage_sram_write_enable;
    logic [2:0] weight_sram_address;
    logic       weight_sram_chip_select;
    logic       weight_sram_write_enable;
    logic [2:0] trace_value_sram_address;
    logic       trace_value_sram_chip_select;
    logic       trace_value_sram_write_enable;
    logic       over_snn_compute;

    // one entry per line of the case file
    logic [7:0] case_pattern [max_cases];
    int         case_lif_lat [max_cases];
    int         case_learn_lat [max_cases];
    int         case_spikes [max_cases];
    int         n_cases;
    logic [3:0] cur_case;
    bit         cases_loaded;

    int         error_count;
    int         check_count;
    int         passes_done;
    int         cycle_cnt;
    int         lif_cnt;
    int         learn_cnt;
    int         spike_cnt;
    int         sp_cycle;
    int         lo_cycle;
    int         proc_cycle;
    int         over_at;
    int         lif_wait;
    int         learn_wait;
    logic [2:0] neuron_num;
    bit         rst_q;
    bit         start_q;
    bit         sv_q;
    bit         lv_q;
    bit         pb_q;
    bit         lif_q;
    bit         learn_q;
    bit         learning;
    bit         next_sv;
    bit         next_spike;
    bit         next_lv;

    snn_scheduler #(
        .neuron_count(neurons)
    ) snn_scheduler_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input int got, input int exp);
        check_count++;
        assert (got == exp) else begin
            $display("ERROR %0t: %s = 'h%0h, expected 'h%0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("%0t: %s", $time, what);
            error_count++;
        end
    endtask

    // memories deselected and no engine pulse
    task automatic check_idle_outputs();
        check_value("chip selects {bias,refractory,voltage,weight,trace}",
                    int'({bias_and_encoders_sram_chip_select, refractory_time_sram_chip_select,
                          voltage_sram_chip_select, weight_sram_chip_select,
                          trace_value_sram_chip_select}), 'h1f);
        check_value("write enables {refractory,voltage,weight,trace}",
                    int'({refractory_time_sram_write_enable, voltage_sram_write_enable,
                          weight_sram_write_enable, trace_value_sram_write_enable}), 'hf);
        check_value("engine pulses", int'({start_lif, start_processing_engine,
                    last_one_processing_engine, spike_output_processing_engine,
                    start_learning_engine, spike_output_learning_engine, over_snn_compute}), 0);
    endtask

    task automatic load_cases(output bit ok);
        int    fd;
        int    got;
        int    pat;
        int    lat_l;
        int    lat_m;
        int    spikes;
        string line;
        ok = 1'b0;
        fd = $fopen("snn_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_cases < max_cases) begin
                got = $fgets(line, fd);
                if (got > 0 && line.getc(0) != "#" &&
                    $sscanf(line, "%h %d %d %d", pat, lat_l, lat_m, spikes) == 4) begin
                    case_pattern[n_cases[3:0]] = pat[7:0];
                    case_lif_lat[n_cases[3:0]] = lat_l;
                    case_learn_lat[n_cases[3:0]] = lat_m;
                    case_spikes[n_cases[3:0]] = spikes;
                    n_cases++;
                end
            end
            $fclose(fd);
            ok = (n_cases > 0);
        end
    endtask

    // engine answers, decided at the falling edge
    always @(posedge clk) begin
        spike_valid <= next_sv;
        spike_output_lif <= next_spike;
        output_valid_learning_engine <= next_lv;
    end

    always @(negedge clk) begin
        bit bit_now;
        bit is_last;
        bit exp_lif;
        bit exp_learn;
        cycle_cnt++;
        next_sv = 1'b0;
        next_spike = 1'b0;
        next_lv = 1'b0;
        exp_lif = 1'b0;
        exp_learn = 1'b0;
        if (!rst || !rst_q) begin
            check_idle_outputs();
        end else begin
            // lif start with the pass start and after every learning result but the last
            exp_lif = start_q || (lv_q && neuron_num != last_num);
            check_value("start_lif", int'(start_lif), int'(exp_lif));
            if (start_lif) begin
                neuron_num = lif_cnt[2:0];
                lif_cnt++;
                lif_wait = case_lif_lat[cur_case];
                check_value("voltage_sram_address", int'(voltage_sram_address), int'(neuron_num));
                check_value("bias_and_encoders_sram_address",
                            int'(bias_and_encoders_sram_address), int'(neuron_num));
                check_value("weight_sram_address", int'(weight_sram_address), int'(neuron_num));
                check_value("trace_value_sram_address",
                            int'(trace_value_sram_address), int'(neuron_num));
                check_value("refractory_time_sram_address",
                            int'(refractory_time_sram_address), int'(neuron_num[2:1]));
                check_value("refractory_time_sram_data_select",
                            int'(refractory_time_sram_data_select), int'(neuron_num[0]));
            end
            bit_now = case_pattern[cur_case][neuron_num];
            is_last = (neuron_num == last_num);
            // memory strobes react one cycle after the engine events, active low
            check_value("{bias_cs,refractory_cs,voltage_cs}",
                        int'({bias_and_encoders_sram_chip_select,
                              refractory_time_sram_chip_select, voltage_sram_chip_select}),
                        (lif_q || sv_q) ? 0 : 'h7);
            check_value("{refractory_we,voltage_we}",
                        int'({refractory_time_sram_write_enable, voltage_sram_write_enable}),
                        sv_q ? 0 : 'h3);
            check_value("weight_sram_chip_select", int'(weight_sram_chip_select),
                        int'(!(pb_q || learn_q || lv_q)));
            check_value("trace_value_sram_chip_select", int'(trace_value_sram_chip_select),
                        int'(!(learn_q || lv_q)));
            check_value("{weight_we,trace_we}",
                        int'({weight_sram_write_enable, trace_value_sram_write_enable}),
                        lv_q ? 0 : 'h3);
            // processing pulses in the cycle after the lif result
            check_value("start_processing_engine", int'(start_processing_engine),
                        int'(sv_q && neuron_num == 3'd0));
            check_value("last_one_processing_engine", int'(last_one_processing_engine),
                        int'(sv_q && is_last));
            check_value("spike_output_processing_engine",
                        int'(spike_output_processing_engine), int'(sv_q && bit_now));
            if (sv_q) begin
                proc_cycle = cycle_cnt;
            end
            if (start_processing_engine) begin
                sp_cycle = cycle_cnt;
            end
            if (last_one_processing_engine) begin
                lo_cycle = cycle_cnt;
            end
            if (spike_output_processing_engine) begin
                spike_cnt++;
            end
            exp_learn = (cycle_cnt == proc_cycle + proc_delay + 1);
            check_value("start_learning_engine", int'(start_learning_engine), int'(exp_learn));
            if (start_learning_engine) begin
                learn_cnt++;
                learn_wait = case_learn_lat[cur_case];
            end
            // spike bit offered for the whole learning stage
            check_value("spike_output_learning_engine", int'(spike_output_learning_engine),
                        int'((exp_learn || learning) && bit_now));
            learning = (exp_learn || learning) && !output_valid_learning_engine;
            if (output_valid_learning_engine && is_last) begin
                over_at = cycle_cnt + 2;
            end
            check_value("over_snn_compute", int'(over_snn_compute), int'(cycle_cnt == over_at));
            if (over_snn_compute) begin
                check_value("start_lif pulses in pass", lif_cnt, neurons);
                check_value("start_learning_engine pulses in pass", learn_cnt, neurons);
                check_value("spike_output_processing_engine pulses in pass", spike_cnt,
                            case_spikes[cur_case]);
                check_true(sp_cycle > 0 && sp_cycle < lo_cycle && lo_cycle < cycle_cnt,
                           "processing start, last neuron and pass end came out of order");
                passes_done++;
            end
        end
        if (lif_wait > 0) begin
            lif_wait--;
            if (lif_wait == 0) begin
                next_sv = 1'b1;
                next_spike = case_pattern[cur_case][neuron_num];
            end
        end
        if (learn_wait > 0) begin
            learn_wait--;
            next_lv = (learn_wait == 0);
        end
        // new pass
        if (start_snn_compute) begin
            lif_cnt = 0;
            learn_cnt = 0;
            spike_cnt = 0;
            sp_cycle = 0;
            lo_cycle = 0;
        end
        start_q = start_snn_compute;
        pb_q = sv_q;
        sv_q = spike_valid;
        lv_q = output_valid_learning_engine;
        lif_q = exp_lif;
        learn_q = exp_learn;
        rst_q = rst;
    end

    initial begin
        bit ok;
        rst <= 1'b0;
        start_snn_compute <= 1'b0;
        spike_valid <= 1'b0;
        spike_output_lif <= 1'b0;
        output_valid_learning_engine <= 1'b0;
        cur_case <= 4'd0;
        load_cases(ok);
        if (!ok) begin
            $display("could not read any case from snn_cases.txt");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            cases_loaded = 1'b1;
            repeat (10) @(posedge clk);
            rst <= 1'b1;
            repeat (3) @(posedge clk);
            for (int i = 0; i < n_cases; i++) begin
                cur_case <= i[3:0];
                start_snn_compute <= 1'b1;
                @(posedge clk);
                start_snn_compute <= 1'b0;
                while (passes_done <= i) @(posedge clk);
                repeat (3) @(posedge clk);
            end
            $display("passes: %0d of %0d, checks: %0d, errors: %0d",
                     passes_done, n_cases, check_count, error_count);
            if (error_count == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

    // watchdog sized from the case latencies
    initial begin
        int limit;
        wait (cases_loaded);
        limit = 40;
        for (int i = 0; i < n_cases; i++) begin
            limit += neurons * (case_lif_lat[i[3:0]] + case_learn_lat[i[3:0]] + 10) + 10;
        end
        repeat (limit) @(posedge clk);
        $display("timeout: the passes did not finish within %0d cycles", limit);
        $display("passes: %0d of %0d, checks: %0d, errors: %0d",
                 passes_done, n_cases, check_count, error_count);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- snn_scheduler.sv
// snn core scheduler top, steps every neuron through lif, processing and learning
`default_nettype none

module snn_scheduler #(
    parameter int unsigned neuron_count = snn_sched_pkg::DEFAULT_NEURON_COUNT,
    localparam int unsigned addr_w = (neuron_count > 2) ? $clog2(neuron_count) : 2
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start_snn_compute,
    input  wire logic              spike_valid,
    input  wire logic              spike_output_lif,
    input  wire logic              output_valid_learning_engine,
    output logic                   start_lif,
    output logic                   start_processing_engine,
    output logic                   last_one_processing_engine,
    output logic                   spike_output_processing_engine,
    output logic                   start_learning_engine,
    output logic                   spike_output_learning_engine,
    output logic [addr_w-1:0]      bias_and_encoders_sram_address,
    output logic                   bias_and_encoders_sram_chip_select,
    output logic [addr_w-2:0]      refractory_time_sram_address,
    output logic                   refractory_time_sram_data_select,
    output logic                   refractory_time_sram_chip_select,
    output logic                   refractory_time_sram_write_enable,
    output logic [addr_w-1:0]      voltage_sram_address,
    output logic                   voltage_sram_chip_select,
    output logic                   voltage_sram_write_enable,
    output logic [addr_w-1:0]      weight_sram_address,
    output logic                   weight_sram_chip_select,
    output logic                   weight_sram_write_enable,
    output logic [addr_w-1:0]      trace_value_sram_address,
    output logic                   trace_value_sram_chip_select,
    output logic                   trace_value_sram_write_enable,
    output logic                   over_snn_compute
);

    // events from the state machine
    logic              lif_begin;
    logic              proc_begin;
    logic              learn_begin;
    logic              pass_done;
    logic              in_learning;
    logic              first_neuron;
    logic              last_neuron;
    logic [addr_w-1:0] neuron_idx;

    sched_fsm #(
        .neuron_count(neuron_count)
    ) sched_fsm_inst (
        .clk                          (clk),
        .rst                          (rst),
        .start_snn_compute            (start_snn_compute),
        .spike_valid                  (spike_valid),
        .output_valid_learning_engine (output_valid_learning_engine),
        .lif_begin                    (lif_begin),
        .proc_begin                   (proc_begin),
        .learn_begin                  (learn_begin),
        .pass_done                    (pass_done),
        .in_learning                  (in_learning),
        .first_neuron                 (first_neuron),
        .last_neuron                  (last_neuron),
        .neuron_idx                   (neuron_idx)
    );

    engine_pulses engine_pulses_inst (
        .clk                            (clk),
        .rst                            (rst),
        .start_snn_compute              (start_snn_compute),
        .spike_valid                    (spike_valid),
        .spike_output_lif               (spike_output_lif),
        .lif_begin                      (lif_begin),
        .proc_begin                     (proc_begin),
        .learn_begin                    (learn_begin),
        .in_learning                    (in_learning),
        .first_neuron                   (first_neuron),
        .last_neuron                    (last_neuron),
        .pass_done                      (pass_done),
        .start_lif                      (start_lif),
        .start_processing_engine        (start_processing_engine),
        .last_one_processing_engine     (last_one_processing_engine),
        .spike_output_processing_engine (spike_output_processing_engine),
        .start_learning_engine          (start_learning_engine),
        .spike_output_learning_engine   (spike_output_learning_engine),
        .over_snn_compute               (over_snn_compute)
    );

    sram_strobes #(
        .neuron_count(neuron_count)
    ) sram_strobes_inst (
        .clk                                (clk),
        .rst                                (rst),
        .neuron_idx                         (neuron_idx),
        .start_lif                          (start_lif),
        .spike_valid                        (spike_valid),
        .proc_begin                         (proc_begin),
        .start_learning_engine              (start_learning_engine),
        .output_valid_learning_engine       (output_valid_learning_engine),
        .bias_and_encoders_sram_address     (bias_and_encoders_sram_address),
        .bias_and_encoders_sram_chip_select (bias_and_encoders_sram_chip_select),
        .refractory_time_sram_address       (refractory_time_sram_address),
        .refractory_time_sram_data_select   (refractory_time_sram_data_select),
        .refractory_time_sram_chip_select   (refractory_time_sram_chip_select),
        .refractory_time_sram_write_enable  (refractory_time_sram_write_enable),
        .voltage_sram_address               (voltage_sram_address),
        .voltage_sram_chip_select           (voltage_sram_chip_select),
        .voltage_sram_write_enable          (voltage_sram_write_enable),
        .weight_sram_address                (weight_sram_address),
        .weight_sram_chip_select            (weight_sram_chip_select),
        .weight_sram_write_enable           (weight_sram_write_enable),
        .trace_value_sram_address           (trace_value_sram_address),
        .trace_value_sram_chip_select       (trace_value_sram_chip_select),
        .trace_value_sram_write_enable      (trace_value_sram_write_enable)
    );

endmodule

`default_nettype wire

//--- sram_strobes.sv
// active-low chip-select and write-enable strobes and addresses for the five neuron memories
`default_nettype none

module sram_strobes #(
    parameter int unsigned neuron_count = snn_sched_pkg::DEFAULT_NEURON_COUNT,
    localparam int unsigned addr_w = (neuron_count > 2) ? $clog2(neuron_count) : 2
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic [addr_w-1:0] neuron_idx,
    input  wire logic              start_lif,
    input  wire logic              spike_valid,
    input  wire logic              proc_begin,
    input  wire logic              start_learning_engine,
    input  wire logic              output_valid_learning_engine,
    output logic [addr_w-1:0]      bias_and_encoders_sram_address,
    output logic                   bias_and_encoders_sram_chip_select,
    output logic [addr_w-2:0]      refractory_time_sram_address,
    output logic                   refractory_time_sram_data_select,
    output logic                   refractory_time_sram_chip_select,
    output logic                   refractory_time_sram_write_enable,
    output logic [addr_w-1:0]      voltage_sram_address,
    output logic                   voltage_sram_chip_select,
    output logic                   voltage_sram_write_enable,
    output logic [addr_w-1:0]      weight_sram_address,
    output logic                   weight_sram_chip_select,
    output logic                   weight_sram_write_enable,
    output logic [addr_w-1:0]      trace_value_sram_address,
    output logic                   trace_value_sram_chip_select,
    output logic                   trace_value_sram_write_enable
);

    logic lif_access;
    logic learn_access;

    // lif reads its operands at start and writes back with the result
    assign lif_access   = start_lif | spike_valid;
    assign learn_access = start_learning_engine | output_valid_learning_engine;

    // all memories are indexed by neuron
    assign bias_and_encoders_sram_address = neuron_idx;
    assign voltage_sram_address           = neuron_idx;
    assign weight_sram_address            = neuron_idx;
    assign trace_value_sram_address       = neuron_idx;

    // two neurons share one refractory word
    assign refractory_time_sram_address     = neuron_idx[addr_w-1:1];
    assign refractory_time_sram_data_select = neuron_idx[0];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bias_and_encoders_sram_chip_select <= 1'b1;
            refractory_time_sram_chip_select   <= 1'b1;
            refractory_time_sram_write_enable  <= 1'b1;
            voltage_sram_chip_select           <= 1'b1;
            voltage_sram_write_enable          <= 1'b1;
            weight_sram_chip_select            <= 1'b1;
            weight_sram_write_enable           <= 1'b1;
            trace_value_sram_chip_select       <= 1'b1;
            trace_value_sram_write_enable      <= 1'b1;
        end else begin
            bias_and_encoders_sram_chip_select <= ~lif_access;
            refractory_time_sram_chip_select   <= ~lif_access;
            refractory_time_sram_write_enable  <= ~spike_valid;
            voltage_sram_chip_select           <= ~lif_access;
            voltage_sram_write_enable          <= ~spike_valid;
            // weights are also read by the processing stage
            weight_sram_chip_select            <= ~(proc_begin | learn_access);
            weight_sram_write_enable           <= ~output_valid_learning_engine;
            trace_value_sram_chip_select       <= ~learn_access;
            trace_value_sram_write_enable      <= ~output_valid_learning_engine;
        end
    end

    a_write_needs_select: assert property (@(posedge clk) disable iff (!rst)
        !((!refractory_time_sram_write_enable && refractory_time_sram_chip_select) ||
          (!voltage_sram_write_enable && voltage_sram_chip_select) ||
          (!weight_sram_write_enable && weight_sram_chip_select) ||
          (!trace_value_sram_write_enable && trace_value_sram_chip_select)))
        else $error("memory write enabled without chip select");

endmodule

`default_nettype wire

//--- engine_pulses.sv
// lif spike latch and start/spike pulses for the lif, processing and learning engines
`default_nettype none

module engine_pulses (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start_snn_compute,
    input  wire logic spike_valid,
    input  wire logic spike_output_lif,
    input  wire logic lif_begin,
    input  wire logic proc_begin,
    input  wire logic learn_begin,
    input  wire logic in_learning,
    input  wire logic first_neuron,
    input  wire logic last_neuron,
    input  wire logic pass_done,
    output logic      start_lif,
    output logic      start_processing_engine,
    output logic      last_one_processing_engine,
    output logic      spike_output_processing_engine,
    output logic      start_learning_engine,
    output logic      spike_output_learning_engine,
    output logic      over_snn_compute
);

    logic spike_q;

    // spike of the current neuron, kept until the next lif result
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            spike_q <= 1'b0;
        end else if (start_snn_compute) begin
            spike_q <= 1'b0;
        end else if (spike_valid) begin
            spike_q <= spike_output_lif;
        end
    end

    assign start_lif = lif_begin;

    // processing engine is started once per pass and told about the last neuron
    assign start_processing_engine        = proc_begin & first_neuron;
    assign last_one_processing_engine     = proc_begin & last_neuron;
    assign spike_output_processing_engine = proc_begin & spike_q;

    assign start_learning_engine        = learn_begin;
    assign spike_output_learning_engine = in_learning & spike_q;

    assign over_snn_compute = pass_done;

    a_lif_learn_apart: assert property (@(posedge clk) disable iff (!rst)
        !(start_lif && start_learning_engine))
        else $error("lif and learning engine started together");

    // learning starts a fixed distance after the processing stage opens
    a_proc_to_learn: assert property (@(posedge clk) disable iff (!rst)
        proc_begin |-> ##(snn_sched_pkg::PROC_DELAY + 1) learn_begin)
        else $error("learning start off the processing delay");

endmodule

`default_nettype wire

//--- sched_fsm.sv
// per-neuron state machine with neuron counter and processing-stage delay line
`default_nettype none

module sched_fsm #(
    parameter int unsigned neuron_count = snn_sched_pkg::DEFAULT_NEURON_COUNT,
    localparam int unsigned addr_w = (neuron_count > 2) ? $clog2(neuron_count) : 2
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start_snn_compute,
    input  wire logic              spike_valid,
    input  wire logic              output_valid_learning_engine,
    output logic                   lif_begin,
    output logic                   proc_begin,
    output logic                   learn_begin,
    output logic                   pass_done,
    output logic                   in_learning,
    output logic                   first_neuron,
    output logic                   last_neuron,
    output logic [addr_w-1:0]      neuron_idx
);

    localparam int proc_len = int'(snn_sched_pkg::PROC_DELAY);

    typedef logic [addr_w-1:0] neuron_addr_t;

    snn_sched_pkg::sched_state_t state;
    snn_sched_pkg::sched_state_t state_nx;
    neuron_addr_t                idx;
    logic [proc_len-1:0]         proc_line;

    assign neuron_idx   = idx;
    assign first_neuron = (idx == '0);
    assign last_neuron  = (idx == neuron_addr_t'(neuron_count - 1));
    assign in_learning  = (state == snn_sched_pkg::st_learning);

    // next state
    always_comb begin
        state_nx = state;
        case (state)
            snn_sched_pkg::st_idle: begin
                if (start_snn_compute) begin
                    state_nx = snn_sched_pkg::st_lif;
                end
            end
            snn_sched_pkg::st_lif: begin
                if (spike_valid) begin
                    state_nx = snn_sched_pkg::st_processing;
                end
            end
            snn_sched_pkg::st_processing: begin
                // leave once the begin pulse has crossed the whole delay line
                if (proc_line[proc_len-1]) begin
                    state_nx = snn_sched_pkg::st_learning;
                end
            end
            snn_sched_pkg::st_learning: begin
                if (output_valid_learning_engine) begin
                    state_nx = last_neuron ? snn_sched_pkg::st_done : snn_sched_pkg::st_lif;
                end
            end
            snn_sched_pkg::st_done: begin
                state_nx = snn_sched_pkg::st_idle;
            end
            default: begin
                state_nx = snn_sched_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= snn_sched_pkg::st_idle;
        end else begin
            state <= state_nx;
        end
    end

    // one-cycle event pulses, taken from the transition being made
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lif_begin   <= 1'b0;
            proc_begin  <= 1'b0;
            learn_begin <= 1'b0;
            pass_done   <= 1'b0;
        end else begin
            lif_begin   <= (state != snn_sched_pkg::st_lif) &&
                           (state_nx == snn_sched_pkg::st_lif);
            proc_begin  <= (state == snn_sched_pkg::st_lif) &&
                           (state_nx == snn_sched_pkg::st_processing);
            learn_begin <= (state == snn_sched_pkg::st_processing) &&
                           (state_nx == snn_sched_pkg::st_learning);
            pass_done   <= (state == snn_sched_pkg::st_done);
        end
    end

    // processing stage timer
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            proc_line <= '0;
        end else begin
            proc_line <= {proc_line[proc_len-2:0], proc_begin};
        end
    end

    // neuron counter, moves on with the learning valid so the next lif sees it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idx <= '0;
        end else if (start_snn_compute) begin
            idx <= '0;
        end else if (in_learning && output_valid_learning_engine && !last_neuron) begin
            idx <= idx + 1'b1;
        end
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot(state))
        else $error("scheduler state lost its one-hot encoding");

    // a new pass may only be requested between passes
    a_start_when_idle: assert property (@(posedge clk) disable iff (!rst)
        start_snn_compute |-> (state == snn_sched_pkg::st_idle))
        else $error("start_snn_compute while a pass is running");

endmodule

`default_nettype wire

//--- snn_sched_pkg.sv
// shared state encoding, stage timing and pass size for the snn neuron scheduler
`default_nettype none

package snn_sched_pkg;

    // one-hot scheduler states, one flop per stage
    typedef enum logic [4:0] {
        st_idle       = 5'b00001,
        st_lif        = 5'b00010,
        st_processing = 5'b00100,
        st_learning   = 5'b01000,
        st_done       = 5'b10000
    } sched_state_t;

    // neuron count of one pass
    typedef logic [10:0] neuron_count_t;

    // cycles spent in the fixed processing stage
    typedef logic [1:0] proc_delay_t;

    // full core size
    localparam neuron_count_t DEFAULT_NEURON_COUNT = 11'd1024;

    // processing engine needs three cycles per neuron
    localparam proc_delay_t PROC_DELAY = 2'd3;

endpackage

`default_nettype wire
